//--- rtl/audio_fft_defs.svh
// --------------------------------------------------
// audio FFT front end, shared size parameters
// --------------------------------------------------
`ifndef AUDIO_FFT_DEFS_SVH
`define AUDIO_FFT_DEFS_SVH

// width of one signed audio sample
`define AFF_SAMPLE_W 24

// FIFO address width, depth is 2**AFF_FIFO_AW
`define AFF_FIFO_AW 10

// samples per FFT frame
`define AFF_FRAME_LEN 256

`endif

//--- rtl/audio_fft_pkg.sv
// --------------------------------------------------
// audio FFT front end, shared types
// --------------------------------------------------
`default_nettype none

`include "audio_fft_defs.svh"

package audio_fft_pkg;

    typedef logic [`AFF_SAMPLE_W-1:0] sample_t;        // one audio sample

    // pointers carry one extra wrap bit above the address
    typedef logic [`AFF_FIFO_AW:0] fifo_ptr_t;
    typedef logic [`AFF_FIFO_AW:0] fifo_count_t;       // 0 .. depth

    typedef logic [$clog2(`AFF_FRAME_LEN)-1:0] frame_idx_t;

    typedef enum logic [0:0] {
        FRAME_IDLE,                                     // waiting for a full frame
        FRAME_STREAM                                    // frame going out to the FFT
    } frame_state_t;

endpackage

`default_nettype wire

//--- rtl/audio_sample_capture.sv
// --------------------------------------------------
// audio capture, writes valid samples into the FIFO
// and flags samples lost to a full buffer
// --------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module audio_sample_capture
    import audio_fft_pkg::*;
(
    input  logic    audio_clk,
    input  logic    rst_n,

    input  logic    audio_valid,
    input  sample_t audio_data,

    input  logic    full,
    output logic    wr_en,
    output sample_t wr_data,

    output logic    overflow
);

logic drop;

// accept only when there is room, the sample lands in memory on this edge
assign wr_en   = audio_valid & ~full;
assign wr_data = audio_data;

// sample offered while the buffer is full
assign drop = audio_valid & full;

// sticky until reset
always_ff @(posedge audio_clk or negedge rst_n)
begin
    if (!rst_n)
    begin
        overflow <= 1'b0;
    end
    else if (drop)
    begin
        overflow <= 1'b1;
    end
end

endmodule

`default_nettype wire

//--- rtl/async_sample_fifo.sv
// --------------------------------------------------
// dual clock FWFT sample FIFO with Gray pointers,
// fill count reported in the read domain
// --------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

`include "audio_fft_defs.svh"

module async_sample_fifo
    import audio_fft_pkg::*;
(
    input  logic        wr_clk,
    input  logic        rd_clk,
    input  logic        rst_n,

    input  logic        wr_en,
    input  sample_t     wr_data,
    output logic        full,

    input  logic        rd_en,
    output sample_t     rd_data,
    output logic        empty,
    output fifo_count_t rd_count
);

localparam int AW    = `AFF_FIFO_AW;
localparam int DEPTH = 1 << AW;

sample_t   mem [DEPTH];

fifo_ptr_t wr_bin;
fifo_ptr_t wr_bin_next;
fifo_ptr_t wr_gray;
fifo_ptr_t rd_gray_s1;       // read pointer seen in write domain
fifo_ptr_t rd_gray_s2;
fifo_ptr_t rd_bin_w;

fifo_ptr_t rd_bin;
fifo_ptr_t rd_bin_next;
fifo_ptr_t rd_gray;
fifo_ptr_t wr_gray_s1;       // write pointer seen in read domain
fifo_ptr_t wr_gray_s2;
fifo_ptr_t wr_bin_r;

function automatic fifo_ptr_t bin2gray(input fifo_ptr_t b);
    return b ^ (b >> 1);
endfunction

function automatic fifo_ptr_t gray2bin(input fifo_ptr_t g);
    fifo_ptr_t b;
    b[AW] = g[AW];
    for (int i = AW - 1; i >= 0; i--)
    begin
        b[i] = b[i + 1] ^ g[i];
    end
    return b;
endfunction

// write domain
assign wr_bin_next = wr_en ? wr_bin + 1'b1 : wr_bin;    // capture already checked full

always_ff @(posedge wr_clk or negedge rst_n)
begin
    if (!rst_n)
    begin
        wr_bin     <= '0;
        wr_gray    <= '0;
        rd_gray_s1 <= '0;
        rd_gray_s2 <= '0;
    end
    else
    begin
        wr_bin     <= wr_bin_next;
        wr_gray    <= bin2gray(wr_bin_next);
        rd_gray_s1 <= rd_gray;
        rd_gray_s2 <= rd_gray_s1;
    end
end

always_ff @(posedge wr_clk)
begin
    if (wr_en)
    begin
        mem[wr_bin[AW-1:0]] <= wr_data;
    end
end

assign rd_bin_w = gray2bin(rd_gray_s2);

// same address, opposite wrap bit
assign full = (wr_bin[AW] != rd_bin_w[AW]) && (wr_bin[AW-1:0] == rd_bin_w[AW-1:0]);

// read domain
assign rd_bin_next = rd_en ? rd_bin + 1'b1 : rd_bin;

always_ff @(posedge rd_clk or negedge rst_n)
begin
    if (!rst_n)
    begin
        rd_bin     <= '0;
        rd_gray    <= '0;
        wr_gray_s1 <= '0;
        wr_gray_s2 <= '0;
    end
    else
    begin
        rd_bin     <= rd_bin_next;
        rd_gray    <= bin2gray(rd_bin_next);
        wr_gray_s1 <= wr_gray;
        wr_gray_s2 <= wr_gray_s1;
    end
end

assign wr_bin_r = gray2bin(wr_gray_s2);

assign rd_data  = mem[rd_bin[AW-1:0]];      // head of queue, fall through
assign empty    = (rd_bin == wr_bin_r);
assign rd_count = wr_bin_r - rd_bin;        // wrap bit keeps this correct at full

endmodule

`default_nettype wire

//--- rtl/fft_frame_ctrl.sv
// --------------------------------------------------
// frame controller, streams one buffered frame at a
// time to the FFT with start and end markers
// --------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

`include "audio_fft_defs.svh"

module fft_frame_ctrl
    import audio_fft_pkg::*;
(
    input  logic        clk_50m,
    input  logic        rst_n,

    input  logic        empty,
    input  fifo_count_t rd_count,
    input  sample_t     rd_data,
    output logic        rd_en,

    output logic        fft_valid,
    output sample_t     fft_data,
    output logic        fft_sop,
    output logic        fft_eop,
    input  logic        fft_ready
);

localparam fifo_count_t FRAME_LEN = fifo_count_t'(`AFF_FRAME_LEN);
localparam frame_idx_t  LAST_IDX  = frame_idx_t'(`AFF_FRAME_LEN - 1);

frame_state_t state;
frame_state_t state_next;
frame_idx_t   idx;          // position of the head sample in the frame
logic         xfer;
logic         last;

// a whole frame is buffered before start, so empty only guards the head
assign fft_valid = (state == FRAME_STREAM) && !empty;
assign xfer      = fft_valid && fft_ready;
assign rd_en     = xfer;                        // pop only on a completed transfer
assign last      = (idx == LAST_IDX);

// head stays put until popped, so data and markers hold under back-pressure
assign fft_data = fft_valid ? rd_data : '0;
assign fft_sop  = fft_valid && (idx == '0);
assign fft_eop  = fft_valid && last;

always_comb
begin
    state_next = state;
    case (state)
        FRAME_IDLE:
        begin
            if (rd_count >= FRAME_LEN)
            begin
                state_next = FRAME_STREAM;
            end
        end
        FRAME_STREAM:
        begin
            if (xfer && last)
            begin
                state_next = FRAME_IDLE;      // at least one idle cycle follows
            end
        end
        default: state_next = FRAME_IDLE;
    endcase
end

always_ff @(posedge clk_50m or negedge rst_n)
begin
    if (!rst_n)
    begin
        state <= FRAME_IDLE;
        idx   <= '0;
    end
    else
    begin
        state <= state_next;
        if (state == FRAME_IDLE)
        begin
            idx <= '0;
        end
        else if (xfer)
        begin
            idx <= last ? '0 : idx + 1'b1;
        end
    end
end

endmodule

`default_nettype wire

//--- rtl/audio_fft_frontend.sv
// --------------------------------------------------
// audio front end for the FFT core, capture, CDC
// FIFO and frame controller
// --------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module audio_fft_frontend
    import audio_fft_pkg::*;
(
    input  logic    clk_50m,
    input  logic    rst_n,

    input  logic    audio_clk,
    input  logic    audio_valid,
    input  sample_t audio_data,
    output logic    overflow,       // audio_clk domain

    input  logic    fft_ready,
    output logic    fft_valid,
    output logic    fft_sop,
    output logic    fft_eop,
    output sample_t fft_data
);

logic        wr_en;
sample_t     wr_data;
logic        full;
logic        rd_en;
sample_t     rd_data;
logic        empty;
fifo_count_t rd_count;

audio_sample_capture u_capture
(
    .audio_clk   (audio_clk  ),
    .rst_n       (rst_n      ),
    .audio_valid (audio_valid),
    .audio_data  (audio_data ),
    .full        (full       ),
    .wr_en       (wr_en      ),
    .wr_data     (wr_data    ),
    .overflow    (overflow   )
);

async_sample_fifo u_fifo
(
    .wr_clk   (audio_clk),
    .rd_clk   (clk_50m  ),
    .rst_n    (rst_n    ),
    .wr_en    (wr_en    ),
    .wr_data  (wr_data  ),
    .full     (full     ),
    .rd_en    (rd_en    ),
    .rd_data  (rd_data  ),
    .empty    (empty    ),
    .rd_count (rd_count )
);

fft_frame_ctrl u_frame_ctrl
(
    .clk_50m   (clk_50m  ),
    .rst_n     (rst_n    ),
    .empty     (empty    ),
    .rd_count  (rd_count ),
    .rd_data   (rd_data  ),
    .rd_en     (rd_en    ),
    .fft_valid (fft_valid),
    .fft_data  (fft_data ),
    .fft_sop   (fft_sop  ),
    .fft_eop   (fft_eop  ),
    .fft_ready (fft_ready)
);

endmodule

`default_nettype wire

//--- test/frame_checker.sv
// --------------------------------------------------
// stream checker, models the expected FFT stream
// from accepted audio samples and compares
// --------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

`include "audio_fft_defs.svh"

module frame_checker
    import audio_fft_pkg::*;
(
    input logic    clk_50m,
    input logic    audio_clk,
    input logic    rst_n,
    input logic    audio_valid,
    input sample_t audio_data,
    input logic    fft_valid,
    input logic    fft_ready,
    input sample_t fft_data,
    input logic    fft_sop,
    input logic    fft_eop
);

sample_t accepted[$];           // samples taken on the audio side since reset
int      pos = 0;               // transfer index since reset
int      xfer_total = 0;
int      frame_total = 0;
int      stream_errors = 0;
logic    stalled = 1'b0;
sample_t held_data;
logic    held_sop;
logic    held_eop;

string   test_name = "reset";
int      test_errors = 0;
int      tests_run = 0;
int      tests_failed = 0;
int      frame_base = 0;
int      xfer_base = 0;
int      error_base = 0;

// expected sample and markers for a given transfer position
function automatic void expect_at(input int p, output sample_t data,
                                  output logic sop, output logic eop);
    data = accepted[p];
    sop  = (p % `AFF_FRAME_LEN) == 0;
    eop  = (p % `AFF_FRAME_LEN) == `AFF_FRAME_LEN - 1;
endfunction

task automatic compare_field(input string field, input sample_t expected, input sample_t actual);
    if (expected !== actual)
    begin
        $display("MISMATCH %s %s at transfer %0d: expected %h, actual %h",
                 test_name, field, pos, expected, actual);
        stream_errors++;
    end
endtask

always @(posedge audio_clk or negedge rst_n)
begin
    if (!rst_n)
    begin
        accepted.delete();
    end
    else if (audio_valid)
    begin
        accepted.push_back(audio_data);     // tests stay below the FIFO depth
    end
end

always @(posedge clk_50m or negedge rst_n)
begin
    sample_t exp_data;
    logic    exp_sop;
    logic    exp_eop;
    if (!rst_n)
    begin
        pos     = 0;
        stalled = 1'b0;
    end
    else
    begin
        // a stalled beat must come back unchanged
        if (stalled && (!fft_valid || fft_data !== held_data
                        || fft_sop !== held_sop || fft_eop !== held_eop))
        begin
            $display("ERROR %s: stream changed while fft_ready was low, transfer %0d",
                     test_name, pos);
            stream_errors++;
        end
        if (fft_valid && fft_ready)
        begin
            if (pos >= accepted.size())
            begin
                $display("ERROR %s: transfer %0d has no audio sample behind it", test_name, pos);
                stream_errors++;
            end
            else
            begin
                expect_at(pos, exp_data, exp_sop, exp_eop);
                compare_field("data", exp_data, fft_data);
                compare_field("sop", sample_t'(exp_sop), sample_t'(fft_sop));
                compare_field("eop", sample_t'(exp_eop), sample_t'(fft_eop));
            end
            pos++;
            xfer_total++;
            if (fft_eop)
            begin
                frame_total++;
            end
        end
        stalled   = fft_valid && !fft_ready;
        held_data = fft_data;
        held_sop  = fft_sop;
        held_eop  = fft_eop;
    end
end

task automatic start_test(input string name);
    test_name  = name;
    frame_base = frame_total;
    xfer_base  = xfer_total;
    error_base = stream_errors + test_errors;
endtask

function automatic int frames_in_test();
    return frame_total - frame_base;
endfunction

function automatic int total_errors();
    return stream_errors + test_errors;
endfunction

task automatic flag_failure(input string msg);
    $display("ERROR %s: %s", test_name, msg);
    test_errors++;
endtask

task automatic end_test(input int frames);
    int errs;
    if (frames_in_test() != frames)
    begin
        $display("MISMATCH %s frame count: expected %0d, actual %0d",
                 test_name, frames, frames_in_test());
        test_errors++;
    end
    if (xfer_total - xfer_base != frames * `AFF_FRAME_LEN)
    begin
        $display("MISMATCH %s transfer count: expected %0d, actual %0d",
                 test_name, frames * `AFF_FRAME_LEN, xfer_total - xfer_base);
        test_errors++;
    end
    errs = stream_errors + test_errors - error_base;
    tests_run++;
    if (errs != 0)
    begin
        tests_failed++;
    end
    $display("test %s: %s, %0d frames, %0d errors",
             test_name, (errs == 0) ? "ok" : "FAILED", frames_in_test(), errs);
endtask

endmodule

`default_nettype wire

//--- test/tb_audio_fft_frontend.sv
// --------------------------------------------------
// testbench for the audio FFT front end
// --------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

`include "audio_fft_defs.svh"

module tb_audio_fft_frontend
    import audio_fft_pkg::*;
();

localparam int     CLK_PERIOD   = 20;
localparam int     AUDIO_PERIOD = 82;
localparam int     TOTAL_FRAMES = 12;      // 2868 samples over all tests, rounded up
localparam longint WATCHDOG_NS  = longint'(TOTAL_FRAMES) * `AFF_FRAME_LEN * AUDIO_PERIOD * 4;

logic    clk_50m;
logic    audio_clk;
logic    rst_n;
logic    audio_valid;
sample_t audio_data;
logic    fft_ready;
logic    fft_valid;
logic    fft_sop;
logic    fft_eop;
sample_t fft_data;
logic    overflow;
logic    random_ready;                      // back-pressure on or off
logic    ready_level;

audio_fft_frontend uut
(
    .clk_50m     (clk_50m    ),
    .rst_n       (rst_n      ),
    .audio_clk   (audio_clk  ),
    .audio_valid (audio_valid),
    .audio_data  (audio_data ),
    .overflow    (overflow   ),
    .fft_ready   (fft_ready  ),
    .fft_valid   (fft_valid  ),
    .fft_sop     (fft_sop    ),
    .fft_eop     (fft_eop    ),
    .fft_data    (fft_data   )
);

frame_checker chk
(
    .clk_50m     (clk_50m        ),
    .audio_clk   (audio_clk      ),
    .rst_n       (rst_n          ),
    .audio_valid (uut.audio_valid),
    .audio_data  (uut.audio_data ),
    .fft_valid   (uut.fft_valid  ),
    .fft_ready   (uut.fft_ready  ),
    .fft_data    (uut.fft_data   ),
    .fft_sop     (uut.fft_sop    ),
    .fft_eop     (uut.fft_eop    )
);

initial
begin
    clk_50m = 1'b0;
    forever #(CLK_PERIOD / 2) clk_50m = ~clk_50m;
end

initial
begin
    audio_clk = 1'b0;
    forever #(AUDIO_PERIOD / 2) audio_clk = ~audio_clk;
end

// ready follows a coin toss or a fixed level
initial
begin
    fft_ready = 1'b0;
    forever
    begin
        @(posedge clk_50m);
        #2;
        fft_ready = random_ready ? (($urandom % 2) == 1) : ready_level;
    end
end

initial
begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, the tests did not complete", WATCHDOG_NS);
    $display("=== FAIL ===");
    $finish;
end

task automatic apply_reset();
    @(posedge clk_50m);
    #2;
    rst_n = 1'b0;
    repeat (5) @(posedge clk_50m);
    #2;
    rst_n = 1'b1;
endtask

// one sample per audio cycle, valid drops after the last one
task automatic send_samples(input int n);
    for (int i = 0; i < n; i++)
    begin
        @(posedge audio_clk);
        #2;
        audio_valid = 1'b1;
        audio_data  = sample_t'($urandom);
    end
    @(posedge audio_clk);
    #2;
    audio_valid = 1'b0;
endtask

task automatic wait_frames(input int n);
    int cycles;
    cycles = 0;
    while (chk.frames_in_test() < n && cycles < n * 4 * `AFF_FRAME_LEN + 200)
    begin
        @(negedge clk_50m);
        cycles++;
    end
    if (chk.frames_in_test() < n)
    begin
        chk.flag_failure($sformatf("timed out waiting for frame %0d", chk.frames_in_test() + 1));
    end
    repeat (300) @(negedge clk_50m);        // room for any extra frame to show up
endtask

task automatic expect_no_stream(input int cycles);
    int high_cycles;
    high_cycles = 0;
    repeat (cycles)
    begin
        @(negedge clk_50m);
        if (fft_valid)
        begin
            high_cycles++;
        end
    end
    if (high_cycles != 0)
    begin
        chk.flag_failure($sformatf("fft_valid high for %0d cycles on a partial frame",
                                   high_cycles));
    end
endtask

initial
begin
    void'($urandom(32'h6808));
    rst_n        = 1'b0;
    audio_valid  = 1'b0;
    audio_data   = '0;
    random_ready = 1'b0;
    ready_level  = 1'b1;
    apply_reset();

    chk.start_test("single_frame");
    send_samples(256);
    wait_frames(1);
    chk.end_test(1);

    chk.start_test("partial_frame");
    send_samples(200);
    expect_no_stream(2000);
    send_samples(56);
    wait_frames(1);
    chk.end_test(1);

    chk.start_test("back_pressure");
    random_ready = 1'b1;
    send_samples(256);
    wait_frames(1);
    random_ready = 1'b0;
    chk.end_test(1);

    chk.start_test("consecutive_frames");
    send_samples(1000);
    wait_frames(3);                         // the 232 left over stay buffered
    chk.end_test(3);

    chk.start_test("overflow");
    ready_level = 1'b0;
    apply_reset();
    send_samples(1000);
    if (overflow !== 1'b0)
    begin
        chk.flag_failure("overflow set before the FIFO could be full");
    end
    send_samples(100);
    if (overflow !== 1'b1)
    begin
        chk.flag_failure("overflow still low after 1100 samples with fft_ready low");
    end
    chk.end_test(0);

    $display("tests run %0d, failed %0d, errors %0d",
             chk.tests_run, chk.tests_failed, chk.total_errors());
    if (chk.tests_failed == 0 && chk.total_errors() == 0)
    begin
        $display("=== PASS ===");
    end
    else
    begin
        $display("=== FAIL ===");
    end
    $finish;
end

endmodule

`default_nettype wire

//--- flist.f
+incdir+rtl
rtl/audio_fft_pkg.sv
rtl/audio_sample_capture.sv
rtl/async_sample_fifo.sv
rtl/fft_frame_ctrl.sv
rtl/audio_fft_frontend.sv
test/frame_checker.sv
test/tb_audio_fft_frontend.sv

//--- run_sim.sh
#!/bin/sh
# build and run the audio FFT front end testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timescale 1ns/1ns -f flist.f \
    --top-module tb_audio_fft_frontend -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

if grep -q "=== FAIL ===" sim.log; then
    echo "simulation reported errors, see sim.log"
    exit 1
fi
echo "simulation finished without errors"
